/* dram_subsys_patterns.txt */
# name op addr wdata enables expected_read (all numbers in hex)
# write rows ignore expected_read, read rows ignore wdata and enables
lane_w0 write 00000020 11111111 f 00000000
lane_w1 write 00000024 22222222 f 00000000
lane_w2 write 00000028 33333333 f 00000000
lane_w3 write 0000002c 44444444 f 00000000
lane_r0 read 00000020 00000000 0 11111111
lane_r1 read 00000024 00000000 0 22222222
lane_r2 read 00000028 00000000 0 33333333
lane_r3 read 0000002c 00000000 0 44444444
lane_w1b write 00000024 deadbeef f 00000000
lane_r1b read 00000024 00000000 0 deadbeef
lane_r0b read 00000020 00000000 0 11111111
lane_r2b read 00000028 00000000 0 33333333
lane_r3b read 0000002c 00000000 0 44444444
part_init write 00000050 a1b2c3d4 f 00000000
part_b0 write 00000050 ffffffee 1 00000000
part_r0 read 00000050 00000000 0 a1b2c3ee
part_b3 write 00000050 77ffffff 8 00000000
part_b12 write 00000050 ff5566ff 6 00000000
part_r read 00000050 00000000 0 775566ee
alias_w write 00000458 0badf00d f 00000000
alias_r read 00000058 00000000 0 0badf00d
alias_r2 read 80000450 00000000 0 775566ee
alias_r3 read fffffc58 00000000 0 0badf00d

/* dram_subsys.f */
mem_bus_pkg.sv
axi_lite_pkg.sv
dram_port_capture.sv
dram_axi_bridge.sv
line_memory.sv
dram_subsys.sv
tb_clock_gen.sv
dram_subsys_tb.sv

/* dram_subsys_tb.sv */
`timescale 1ns/1ns

module dram_subsys_tb;

  localparam int FILL_BASE    = 16;  // first line of the random fill
  localparam int FILL_LINES   = 4;
  localparam int FILL_PARTIAL = 6;
  localparam int FILL_REQS    = FILL_LINES * 8 + FILL_PARTIAL;

  logic        clk;
  logic        rst;
  logic        oe;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  we;
  logic [31:0] rdata;
  logic        rvalid;
  logic        wdone;
  logic        busy;

  // requests in flight, oldest first
  string       name_q[$];
  bit          write_q[$];
  logic [31:0] exp_q[$];

  string       pat_name[$];
  string       pat_op[$];
  logic [31:0] pat_addr[$];
  logic [31:0] pat_wdata[$];
  logic [3:0]  pat_be[$];
  logic [31:0] pat_exp[$];

  logic [127:0] ref_line [FILL_LINES];
  int           seed = 32'hfd49;
  int           pass_count = 0;
  int           fail_count = 0;
  int           cycles = 0;
  int           cycle_limit = 0;
  string        done_name;
  bit           done_write;
  logic [31:0]  done_exp;

  tb_clock_gen #(.PERIOD(8)) clock_inst (.clk(clk));

  dram_subsys dram_subsys_inst (
    .clk(clk), .rst(rst),
    .oe(oe), .addr(addr), .wdata(wdata), .we(we),
    .rdata(rdata), .rvalid(rvalid), .wdone(wdone), .busy(busy)
  );

  // called on a falling edge, returns on the next one
  task automatic issue_request(input string name, input bit is_write,
                               input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] be, input logic [31:0] expected);
    while (busy) @(negedge clk);
    name_q.push_back(name);
    write_q.push_back(is_write);
    exp_q.push_back(expected);
    oe    = 1'b1;
    addr  = a;
    wdata = is_write ? d : 32'h0;
    we    = is_write ? be : 4'h0;
    @(negedge clk);
    oe = 1'b0;
    we = 4'h0;
  endtask

  // byte enables pick which bytes of the lane take the new word
  task automatic merge_into_ref(input int ln, input int lane, input logic [31:0] d,
                                input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) ref_line[ln][lane*32 + b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  task automatic load_patterns(output bit ok);
    int          fd;
    int          n;
    string       text;
    string       nm;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] x;
    logic [3:0]  be;
    ok = 1'b0;
    fd = $fopen("dram_subsys_patterns.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      if (n > 0 && text.getc(0) != "#") begin
        n = $sscanf(text, "%s %s %h %h %h %h", nm, op, a, d, be, x);
        if (n == 6) begin
          pat_name.push_back(nm);
          pat_op.push_back(op);
          pat_addr.push_back(a);
          pat_wdata.push_back(d);
          pat_be.push_back(be);
          pat_exp.push_back(x);
        end
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  // completions, sampled away from the rising edge
  always @(negedge clk) begin
    if (!rst && (rvalid || wdone)) begin
      if (rvalid && wdone) begin
        $display("FAIL rvalid and wdone pulsed in the same cycle");
        fail_count++;
      end else if (name_q.size() == 0) begin
        $display("FAIL completion pulse seen with no request outstanding");
        fail_count++;
      end else begin
        done_name  = name_q.pop_front();
        done_write = write_q.pop_front();
        done_exp   = exp_q.pop_front();
        if (done_write && !wdone) begin
          $display("FAIL %s: write request ended with a read completion", done_name);
          fail_count++;
        end else if (!done_write && !rvalid) begin
          $display("FAIL %s: read request ended with a write completion", done_name);
          fail_count++;
        end else if (!done_write && rdata !== done_exp) begin
          $display("FAIL %s expected %h actual %h", done_name, done_exp, rdata);
          fail_count++;
        end else begin
          $display("PASS %s", done_name);
          pass_count++;
        end
      end
    end
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (name_q.size() > 0) $display("ERROR: timeout, request %s never completed", name_q[0]);
    else $display("ERROR: timeout, host port never left busy");
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    bit          ok;
    bit          idle_ok;
    int          l;
    int          k;
    logic [31:0] d;
    logic [31:0] a;
    logic [3:0]  be;
    rst   = 1'b1;
    oe    = 1'b0;
    addr  = 32'h0;
    wdata = 32'h0;
    we    = 4'h0;
    load_patterns(ok);
    if (!ok) begin
      $display("ERROR: could not open dram_subsys_patterns.txt");
      fail_count++;
    end
    cycle_limit = 40 * (pat_name.size() + FILL_REQS) + 200;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    idle_ok = 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (idle_ok && (busy !== 1'b0 || rvalid !== 1'b0 || wdone !== 1'b0)) begin
        $display("FAIL reset_idle expected 000 actual %b%b%b", busy, rvalid, wdone);
        idle_ok = 1'b0;
      end
    end
    if (idle_ok) begin
      $display("PASS reset_idle");
      pass_count++;
    end else begin
      fail_count++;
    end

    // each request goes out as soon as busy drops
    for (int i = 0; i < pat_name.size(); i++) begin
      if (pat_op[i] == "write") begin
        issue_request(pat_name[i], 1'b1, pat_addr[i], pat_wdata[i], pat_be[i], 32'h0);
      end else if (pat_op[i] == "read") begin
        issue_request(pat_name[i], 1'b0, pat_addr[i], 32'h0, 4'h0, pat_exp[i]);
      end else begin
        $display("ERROR: pattern %s has unknown operation %s", pat_name[i], pat_op[i]);
        fail_count++;
      end
    end

    for (l = 0; l < FILL_LINES; l++) begin
      for (k = 0; k < 4; k++) begin
        d = $random(seed);
        a = ((FILL_BASE + l) << 4) | (k << 2);
        merge_into_ref(l, k, d, 4'hf);
        issue_request($sformatf("fill_wr_%0d_%0d", l, k), 1'b1, a, d, 4'hf, 32'h0);
      end
    end
    for (int n = 0; n < FILL_PARTIAL; n++) begin
      l  = {$random(seed)} % FILL_LINES;
      k  = {$random(seed)} % 4;
      d  = $random(seed);
      be = 4'($random(seed));
      if (be == 4'h0) be = 4'h5;  // zero enables would be a read
      a = ((FILL_BASE + l) << 4) | (k << 2);
      merge_into_ref(l, k, d, be);
      issue_request($sformatf("fill_part_%0d", n), 1'b1, a, d, be, 32'h0);
    end
    for (l = 0; l < FILL_LINES; l++) begin
      for (k = 0; k < 4; k++) begin
        a = ((FILL_BASE + l) << 4) | (k << 2);
        issue_request($sformatf("fill_rd_%0d_%0d", l, k), 1'b0, a, 32'h0, 4'h0,
                      ref_line[l][k*32 +: 32]);
      end
    end

    while (name_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // late or extra pulses
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;  // 50% duty

endmodule

/* dram_subsys.sv */
`timescale 1ns/1ns

module dram_subsys #(
  parameter int LINE_DEPTH   = 64,
  parameter int RESP_LATENCY = 3
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             oe,
  input  logic [mem_bus_pkg::WORD_W-1:0]   addr,
  input  logic [mem_bus_pkg::WORD_W-1:0]   wdata,
  input  logic [mem_bus_pkg::WORD_W/8-1:0] we,
  output logic [mem_bus_pkg::WORD_W-1:0]   rdata,
  output logic                             rvalid,
  output logic                             wdone,
  output logic                             busy
);

  mem_bus_pkg::mem_req_t req;
  logic                  req_valid;
  logic                  req_ready;

  // AXI4-Lite between bridge and memory
  axi_lite_pkg::axi_aw_t aw;
  axi_lite_pkg::axi_w_t  w;
  axi_lite_pkg::axi_b_t  b;
  axi_lite_pkg::axi_ar_t ar;
  axi_lite_pkg::axi_r_t  r;
  logic aw_valid, aw_ready;
  logic w_valid, w_ready;
  logic b_valid, b_ready;
  logic ar_valid, ar_ready;
  logic r_valid, r_ready;

  dram_port_capture capture_inst (
    .clk(clk), .rst(rst),
    .oe(oe), .addr(addr), .wdata(wdata), .we(we),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .busy(busy)
  );

  dram_axi_bridge bridge_inst (
    .clk(clk), .rst(rst),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b(b), .b_valid(b_valid), .b_ready(b_ready),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .rdata(rdata), .rvalid(rvalid), .wdone(wdone)
  );

  line_memory #(
    .LINE_DEPTH(LINE_DEPTH),
    .RESP_LATENCY(RESP_LATENCY)
  ) memory_inst (
    .clk(clk), .rst(rst),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b(b), .b_valid(b_valid), .b_ready(b_ready),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready)
  );

endmodule

/* line_memory.sv */
`timescale 1ns/1ns

module line_memory #(
  parameter int LINE_DEPTH   = 64,
  parameter int RESP_LATENCY = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  axi_lite_pkg::axi_aw_t aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_lite_pkg::axi_w_t  w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output axi_lite_pkg::axi_b_t  b,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  axi_lite_pkg::axi_ar_t ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output axi_lite_pkg::axi_r_t  r,
  output logic                  r_valid,
  input  logic                  r_ready
);

  localparam int         IDX_W  = $clog2(LINE_DEPTH);
  localparam logic [3:0] LAT_M1 = 4'(RESP_LATENCY - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e                 state;
  logic [3:0]             cnt;
  logic                   aw_got;
  logic                   w_got;
  logic                   is_read;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   ar_fire;
  logic                   wr_accept;
  logic [IDX_W-1:0]       idx_q;
  mem_bus_pkg::mem_line_u wr_line;
  logic [mem_bus_pkg::LINE_W/8-1:0] wr_strb;
  mem_bus_pkg::mem_line_u mem [LINE_DEPTH];

  assign aw_fire   = aw_valid && aw_ready;
  assign w_fire    = w_valid && w_ready;
  assign ar_fire   = ar_valid && ar_ready;
  assign wr_accept = (aw_got || aw_fire) && (w_got || w_fire);

  assign b = '{resp: axi_lite_pkg::RESP_OKAY};
  assign r = '{data: mem[idx_q], resp: axi_lite_pkg::RESP_OKAY};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      is_read  <= 1'b0;
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      ar_ready <= 1'b0;
      b_valid  <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      ar_ready <= 1'b0;
      case (state)
        ST_IDLE: begin
          // ready one cycle after valid, each channel on its own
          aw_ready <= aw_valid & ~aw_ready & ~aw_got;
          w_ready  <= w_valid & ~w_ready & ~w_got;
          ar_ready <= ar_valid & ~ar_ready & ~aw_valid & ~w_valid & ~aw_got & ~w_got;
          if (aw_fire) aw_got <= 1'b1;
          if (w_fire) w_got <= 1'b1;
          if (wr_accept || ar_fire) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            is_read <= ar_fire;
            if (RESP_LATENCY == 1) begin
              state   <= ST_RESP;
              r_valid <= ar_fire;
              b_valid <= ~ar_fire;
            end else begin
              state <= ST_WAIT;
              cnt   <= LAT_M1;
            end
          end
        end
        ST_WAIT: begin
          cnt <= cnt - 4'd1;
          if (cnt == 4'd1) begin
            state   <= ST_RESP;
            r_valid <= is_read;
            b_valid <= ~is_read;
          end
        end
        ST_RESP: begin
          if ((r_valid && r_ready) || (b_valid && b_ready)) begin
            state   <= ST_IDLE;
            r_valid <= 1'b0;
            b_valid <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) idx_q <= aw.addr[4 +: IDX_W];  // line index wraps modulo depth
    if (ar_fire) idx_q <= ar.addr[4 +: IDX_W];
    if (w_fire) begin
      wr_line <= w.data;
      wr_strb <= w.strb;
    end
    // merge strobed bytes as the write response goes out
    if (state == ST_RESP && b_valid && b_ready) begin
      for (int i = 0; i < mem_bus_pkg::LINE_W / 8; i++) begin
        if (wr_strb[i]) mem[idx_q].bytes[i] <= wr_line.bytes[i];
      end
    end
  end

endmodule

/* dram_axi_bridge.sv */
`timescale 1ns/1ns

module dram_axi_bridge (
  input  logic                           clk,
  input  logic                           rst,
  input  mem_bus_pkg::mem_req_t          req,
  input  logic                           req_valid,
  output logic                           req_ready,
  output axi_lite_pkg::axi_aw_t          aw,
  output logic                           aw_valid,
  input  logic                           aw_ready,
  output axi_lite_pkg::axi_w_t           w,
  output logic                           w_valid,
  input  logic                           w_ready,
  input  axi_lite_pkg::axi_b_t           b,
  input  logic                           b_valid,
  output logic                           b_ready,
  output axi_lite_pkg::axi_ar_t          ar,
  output logic                           ar_valid,
  input  logic                           ar_ready,
  input  axi_lite_pkg::axi_r_t           r,
  input  logic                           r_valid,
  output logic                           r_ready,
  output logic [mem_bus_pkg::WORD_W-1:0] rdata,
  output logic                           rvalid,
  output logic                           wdone
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READING,
    ST_WRITING
  } state_e;

  state_e                          state;
  mem_bus_pkg::mem_line_u          wr_line;
  logic [axi_lite_pkg::AXI_STRB_W-1:0] wr_strb;
  mem_bus_pkg::mem_line_u          rd_line;
  logic                            accept;

  assign req_ready = (state == ST_IDLE);
  assign accept    = req_valid && req_ready;
  assign b_ready   = 1'b1;
  assign r_ready   = 1'b1;
  assign rd_line   = r.data;

  // word and enables go to the lane picked by addr[3:2]
  always_comb begin
    wr_line = '0;
    wr_line.words[req.addr[3:2]] = req.wdata;
    wr_strb = '0;
    wr_strb[{req.addr[3:2], 2'b00} +: 4] = req.be;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      ar_valid <= 1'b0;
      rvalid   <= 1'b0;
      wdone    <= 1'b0;
    end else begin
      rvalid <= 1'b0;  // one-cycle pulses
      wdone  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            if (req.kind == mem_bus_pkg::REQ_WRITE) begin
              state    <= ST_WRITING;
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
            end else begin
              state    <= ST_READING;
              ar_valid <= 1'b1;
            end
          end
        end
        ST_READING: begin
          ar_valid <= ar_valid & ~ar_ready;
          if (r_valid) begin
            state  <= ST_IDLE;
            rvalid <= 1'b1;
          end
        end
        ST_WRITING: begin
          aw_valid <= aw_valid & ~aw_ready;
          w_valid  <= w_valid & ~w_ready;
          if (b_valid) begin
            state <= ST_IDLE;
            wdone <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      aw.addr <= req.addr;
      aw.prot <= axi_lite_pkg::PROT_DATA;
      ar.addr <= req.addr;
      ar.prot <= axi_lite_pkg::PROT_DATA;
      w.data  <= wr_line;
      w.strb  <= wr_strb;
    end
    // ar.addr still holds the lane of the pending read
    if (state == ST_READING && r_valid) rdata <= rd_line.words[ar.addr[3:2]];
  end

endmodule

/* dram_port_capture.sv */
`timescale 1ns/1ns

module dram_port_capture (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             oe,
  input  logic [mem_bus_pkg::WORD_W-1:0]   addr,
  input  logic [mem_bus_pkg::WORD_W-1:0]   wdata,
  input  logic [mem_bus_pkg::WORD_W/8-1:0] we,
  output mem_bus_pkg::mem_req_t            req,
  output logic                             req_valid,
  input  logic                             req_ready,
  output logic                             busy
);

  logic full;
  logic load;

  assign load = oe && !full;  // oe while busy is dropped

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (req_valid && req_ready) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      req.addr  <= addr;
      req.wdata <= wdata;
      req.be    <= we;
      // any enabled byte makes it a write
      req.kind  <= (|we) ? mem_bus_pkg::REQ_WRITE : mem_bus_pkg::REQ_READ;
    end
  end

  assign req_valid = full;
  assign busy      = full;

endmodule

/* axi_lite_pkg.sv */
package axi_lite_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = mem_bus_pkg::LINE_W;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [2:0] PROT_DATA = 3'b000;  // unprivileged, secure, data

  // write address
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [2:0]            prot;
  } axi_aw_t;

  // read address
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [2:0]            prot;
  } axi_ar_t;

  // write data
  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi_w_t;

  // read data
  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
  } axi_r_t;

  // write response
  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

/* mem_bus_pkg.sv */
package mem_bus_pkg;

  localparam int WORD_W = 32;
  localparam int LINE_W = 128;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_kind_e;

  // host request as held in the pending slot
  typedef struct packed {
    logic [WORD_W-1:0]   addr;
    logic [WORD_W-1:0]   wdata;
    logic [WORD_W/8-1:0] be;
    req_kind_e           kind;
  } mem_req_t;

  // one memory line, seen as words or as bytes
  typedef union packed {
    logic [LINE_W/WORD_W-1:0][WORD_W-1:0] words;
    logic [LINE_W/8-1:0][7:0]             bytes;
  } mem_line_u;

endpackage
